// File: hw/rvPkg.sv
`default_nettype none

package rvPkg;

    // Base opcodes of the supported subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    localparam logic [2:0] funct3Beq = 3'b000;
    localparam logic [2:0] funct3Bne = 3'b001;

    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,
        aluAnd   = 3'd2,
        aluOr    = 3'd3,
        aluSlt   = 3'd4,
        aluPassB = 3'd5   // lui
    } aluOpE;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immJ = 3'd3,
        immU = 3'd4
    } immSrcE;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,   // Register file value
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelE;

    typedef enum logic [1:0] {
        resAlu = 2'd0,
        resMem = 2'd1,
        resPc4 = 2'd2     // Link value of jal and jalr
    } resultSrcE;

    typedef logic [31:0] instrT;

    localparam instrT nopInstr = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [31:0] resetPc = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hw/pipeCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pipeCtrlIf;
    import rvPkg::*;

    // Decoded controls, per stage
    immSrcE       immSrcD;
    logic         aluSrcE;
    rvPkg::aluOpE aluOpE;
    resultSrcE    resultSrcW;
    logic         regWriteW;
    logic         memWriteM;
    logic         isBranchE;
    logic         isJumpE;

    // Hazard unit outputs
    fwdSelE       forwardAE;
    fwdSelE       forwardBE;
    logic         stallF;
    logic         stallD;
    logic         flushD;
    logic         flushE;

    // Instruction fields and register indices from the datapath
    logic [6:0]   opD;
    logic [2:0]   funct3D;
    logic         funct7b5D;
    logic [4:0]   rs1D;
    logic [4:0]   rs2D;
    logic [4:0]   rs1E;
    logic [4:0]   rs2E;
    logic [4:0]   rdE;
    logic [4:0]   rdM;
    logic [4:0]   rdW;
    logic         mispredictE;

    modport ctrl (
        output immSrcD, aluSrcE, aluOpE, resultSrcW, regWriteW, memWriteM,
        output isBranchE, isJumpE, forwardAE, forwardBE,
        output stallF, stallD, flushD, flushE,
        input  opD, funct3D, funct7b5D, rs1D, rs2D,
        input  rs1E, rs2E, rdE, rdM, rdW, mispredictE
    );

    modport dp (
        input  immSrcD, aluSrcE, aluOpE, resultSrcW, regWriteW, memWriteM,
        input  isBranchE, isJumpE, forwardAE, forwardBE,
        input  stallF, stallD, flushD, flushE,
        output opD, funct3D, funct7b5D, rs1D, rs2D,
        output rs1E, rs2E, rdE, rdM, rdW, mispredictE
    );

endinterface

`default_nettype wire

// File: hw/branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictor #(
    parameter int btbEntries = 32,
    parameter int ghrBits    = 5
) (
    input  wire                clk,
    input  wire                reset,
    input  wire  [31:0]        pcF_i,
    output logic               predTaken_o,
    output logic [31:0]        predTarget_o,
    output logic [ghrBits-1:0] phtIdxF_o,
    input  wire                updValid_i,
    input  wire  [31:0]        updPc_i,
    input  wire  [31:0]        updTarget_i,
    input  wire                updTaken_i,
    input  wire                updIsJump_i,
    input  wire  [ghrBits-1:0] updPhtIdx_i
);
    localparam int idxBits    = $clog2(btbEntries);
    localparam int tagBits    = 30 - idxBits;
    localparam int phtEntries = 1 << ghrBits;

    logic               btbValid  [btbEntries];
    logic               btbJump   [btbEntries];
    logic [tagBits-1:0] btbTag    [btbEntries];
    logic [31:0]        btbTarget [btbEntries];
    logic [1:0]         pht       [phtEntries];
    logic [ghrBits-1:0] ghr;
    logic [idxBits-1:0] idxF;
    logic [idxBits-1:0] idxU;
    logic               hitF;
    logic [1:0]         ctrU;

    // Fetch lookup
    assign idxF         = pcF_i[idxBits+1:2];
    assign hitF         = btbValid[idxF] && (btbTag[idxF] == pcF_i[31:idxBits+2]);
    assign phtIdxF_o    = ghr ^ pcF_i[ghrBits+1:2];   // gshare
    assign predTaken_o  = hitF && (btbJump[idxF] || pht[phtIdxF_o][1]);
    assign predTarget_o = btbTarget[idxF];

    assign idxU = updPc_i[idxBits+1:2];
    assign ctrU = pht[updPhtIdx_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < btbEntries; i++) btbValid[i] <= 1'b0;
            for (int i = 0; i < phtEntries; i++) pht[i] <= 2'b01;   // Weakly not-taken
        end else if (updValid_i) begin
            if (updTaken_i) btbValid[idxU] <= 1'b1;
            if (!updIsJump_i) begin
                ghr <= {ghr[ghrBits-2:0], updTaken_i};
                if (updTaken_i && ctrU != 2'b11) begin
                    pht[updPhtIdx_i] <= ctrU + 2'd1;
                end else if (!updTaken_i && ctrU != 2'b00) begin
                    pht[updPhtIdx_i] <= ctrU - 2'd1;
                end
            end
        end
    end

    // BTB entry payload
    always_ff @(posedge clk) begin
        if (updValid_i && updTaken_i) begin
            btbTag[idxU]    <= updPc_i[31:idxBits+2];
            btbTarget[idxU] <= updTarget_i;
            btbJump[idxU]   <= updIsJump_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire         clk,
    input  wire         reset,
    input  wire  [4:0]  ra1_i,
    input  wire  [4:0]  ra2_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o,
    input  wire         we_i,
    input  wire  [4:0]  wa_i,
    input  wire  [31:0] wd_i
);
    logic [31:0] regs [1:31];   // x0 has no storage

    // Same-cycle write is visible on the read side
    function automatic logic [31:0] readPort(input logic [4:0] ra);
        if (ra == 5'd0) return 32'd0;
        if (we_i && wa_i == ra) return wd_i;
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) regs[i] <= 32'd0;
        end else if (we_i && wa_i != 5'd0) begin
            regs[wa_i] <= wd_i;
        end
    end

    always_comb begin
        rd1_o = readPort(ra1_i);
        rd2_o = readPort(ra2_i);
    end

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire  [31:0]        a_i,
    input  wire  [31:0]        b_i,
    input  wire  rvPkg::aluOpE op_i,
    output logic [31:0]        result_o,
    output logic               zero_o
);
    import rvPkg::*;

    always_comb begin
        case (op_i)
            aluSub:   result_o = a_i - b_i;
            aluAnd:   result_o = a_i & b_i;
            aluOr:    result_o = a_i | b_i;
            aluSlt:   result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            aluPassB: result_o = b_i;
            default:  result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == 32'd0);   // beq and bne use sub

endmodule

`default_nettype wire

// File: hw/pipeControl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeControl (
    input  wire       clk,
    input  wire       reset,
    pipeCtrlIf.ctrl   ctrl
);
    import rvPkg::*;

    logic      regWriteD;
    logic      memWriteD;
    logic      aluSrcD;
    logic      branchD;
    resultSrcE resSrcD;
    aluOpE     aluOpD;
    aluOpE     aluFunctD;
    logic      regWriteE;
    logic      memWriteE;
    resultSrcE resSrcE;
    logic      regWriteM;
    resultSrcE resSrcM;
    logic      lwStall;

    // Picks the nearest producer of rs, memory stage first
    function automatic fwdSelE fwdSel(input logic [4:0] rs);
        if (rs != 5'd0 && rs == ctrl.rdM && regWriteM) return fwdMem;
        if (rs != 5'd0 && rs == ctrl.rdW && ctrl.regWriteW) return fwdWb;
        return fwdNone;
    endfunction

    // ALU op from funct3, shared by register and immediate forms
    always_comb begin
        case (ctrl.funct3D)
            3'b010:  aluFunctD = aluSlt;
            3'b110:  aluFunctD = aluOr;
            3'b111:  aluFunctD = aluAnd;
            default: aluFunctD = (ctrl.opD == opReg && ctrl.funct7b5D) ? aluSub : aluAdd;
        endcase
    end

    // Main decoder
    always_comb begin
        regWriteD    = 1'b0;
        memWriteD    = 1'b0;
        aluSrcD      = 1'b0;
        branchD      = 1'b0;
        resSrcD      = resAlu;
        aluOpD       = aluAdd;
        ctrl.immSrcD = immI;
        case (ctrl.opD)
            opLui: begin
                regWriteD    = 1'b1;
                aluSrcD      = 1'b1;
                aluOpD       = aluPassB;
                ctrl.immSrcD = immU;
            end
            opImm: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = aluFunctD;
            end
            opReg: begin
                regWriteD = 1'b1;
                aluOpD    = aluFunctD;
            end
            opLoad: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                resSrcD   = resMem;
            end
            opStore: begin
                memWriteD    = 1'b1;
                aluSrcD      = 1'b1;
                ctrl.immSrcD = immS;
            end
            opBranch: begin
                branchD      = 1'b1;
                aluOpD       = aluSub;
                ctrl.immSrcD = immB;
            end
            opJal: begin
                regWriteD    = 1'b1;
                resSrcD      = resPc4;
                ctrl.immSrcD = immJ;
            end
            opJalr: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;   // Target is rs1 + imm
                resSrcD   = resPc4;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            regWriteE      <= 1'b0;
            memWriteE      <= 1'b0;
            ctrl.isBranchE <= 1'b0;
            resSrcE        <= resAlu;
        end else begin
            regWriteE      <= regWriteD;
            memWriteE      <= memWriteD;
            ctrl.isBranchE <= branchD;
            resSrcE        <= resSrcD;
        end
    end

    always_ff @(posedge clk) begin
        ctrl.aluSrcE <= aluSrcD;
        ctrl.aluOpE  <= aluOpD;
    end

    assign ctrl.isJumpE = (resSrcE == resPc4);

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM       <= 1'b0;
            resSrcM         <= resAlu;
            ctrl.memWriteM  <= 1'b0;
            ctrl.regWriteW  <= 1'b0;
            ctrl.resultSrcW <= resAlu;
        end else begin
            regWriteM       <= regWriteE;
            resSrcM         <= resSrcE;
            ctrl.memWriteM  <= memWriteE;
            ctrl.regWriteW  <= regWriteM;
            ctrl.resultSrcW <= resSrcM;
        end
    end

    always_comb begin
        ctrl.forwardAE = fwdSel(ctrl.rs1E);
        ctrl.forwardBE = fwdSel(ctrl.rs2E);
    end

    // Load in execute feeding the instruction in decode
    assign lwStall = (resSrcE == resMem) && (ctrl.rdE != 5'd0) &&
                     (ctrl.rdE == ctrl.rs1D || ctrl.rdE == ctrl.rs2D);

    assign ctrl.stallF = lwStall && !ctrl.mispredictE;   // Redirect wins
    assign ctrl.stallD = lwStall && !ctrl.mispredictE;
    assign ctrl.flushD = ctrl.mispredictE;
    assign ctrl.flushE = lwStall || ctrl.mispredictE;

endmodule

`default_nettype wire

// File: hw/pipeDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module pipeDatapath #(
    parameter int ghrBits = 5
) (
    input  wire                clk,
    input  wire                reset,
    pipeCtrlIf.dp              dp,
    output logic [31:0]        imemAddr_o,
    input  wire  rvPkg::instrT imemData_i,
    output logic [4:0]         ra1_o,
    output logic [4:0]         ra2_o,
    input  wire  [31:0]        rd1_i,
    input  wire  [31:0]        rd2_i,
    output logic               rfWe_o,
    output logic [4:0]         rfWa_o,
    output logic [31:0]        rfWd_o,
    output logic [31:0]        aluA_o,
    output logic [31:0]        aluB_o,
    output rvPkg::aluOpE       aluOp_o,
    input  wire  [31:0]        aluRes_i,
    input  wire                aluZero_i,
    input  wire                predTaken_i,
    input  wire  [31:0]        predTarget_i,
    input  wire  [ghrBits-1:0] phtIdx_i,
    output logic               updValid_o,
    output logic [31:0]        updPc_o,
    output logic [31:0]        updTarget_o,
    output logic               updTaken_o,
    output logic               updIsJump_o,
    output logic [ghrBits-1:0] updPhtIdx_o,
    output logic [31:0]        dmemAddr_o,
    output logic [31:0]        dmemWData_o,
    output logic               dmemWe_o,
    input  wire  [31:0]        dmemRData_i
);
    import rvPkg::*;

    logic [31:0]        pcF, pc4F, pcNextF;
    instrT              instrD;
    logic [31:0]        pcD, pc4D, immD, predTargetD;
    logic               predTakenD;
    logic [ghrBits-1:0] phtIdxD;
    logic [31:0]        pcE, pc4E, immE, rd1E, rd2E, predTargetE;
    logic               predTakenE;
    logic               jalrE;
    logic [2:0]         funct3E;
    logic [ghrBits-1:0] phtIdxE;
    logic [31:0]        srcAE, writeDataE, exResE, targetE, redirectE;
    logic               takenE;
    logic [31:0]        exResM, writeDataM;
    logic [31:0]        exResW, readDataW, resultW;

    // Fetch
    assign pc4F       = pcF + 32'd4;
    assign imemAddr_o = pcF;

    always_comb begin
        if (dp.mispredictE) pcNextF = redirectE;
        else if (predTaken_i) pcNextF = predTarget_i;
        else pcNextF = pc4F;
    end

    always_ff @(posedge clk) begin
        if (reset) pcF <= resetPc;
        else if (!dp.stallF) pcF <= pcNextF;
    end

    // Decode
    always_ff @(posedge clk) begin
        if (reset || dp.flushD) begin
            instrD     <= nopInstr;
            predTakenD <= 1'b0;
        end else if (!dp.stallD) begin
            instrD     <= imemData_i;
            predTakenD <= predTaken_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!dp.stallD) begin
            pcD         <= pcF;
            pc4D        <= pc4F;
            predTargetD <= predTarget_i;
            phtIdxD     <= phtIdx_i;
        end
    end

    assign dp.opD       = instrD[6:0];
    assign dp.funct3D   = instrD[14:12];
    assign dp.funct7b5D = instrD[30];
    assign dp.rs1D      = instrD[19:15];
    assign dp.rs2D      = instrD[24:20];
    assign ra1_o        = instrD[19:15];
    assign ra2_o        = instrD[24:20];

    always_comb begin
        case (dp.immSrcD)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'd0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // Execute
    always_ff @(posedge clk) begin
        if (reset || dp.flushE) begin
            dp.rs1E    <= 5'd0;
            dp.rs2E    <= 5'd0;
            dp.rdE     <= 5'd0;
            predTakenE <= 1'b0;
        end else begin
            dp.rs1E    <= instrD[19:15];
            dp.rs2E    <= instrD[24:20];
            dp.rdE     <= instrD[11:7];
            predTakenE <= predTakenD;
        end
    end

    always_ff @(posedge clk) begin
        pcE         <= pcD;
        pc4E        <= pc4D;
        immE        <= immD;
        rd1E        <= rd1_i;
        rd2E        <= rd2_i;
        predTargetE <= predTargetD;
        phtIdxE     <= phtIdxD;
        funct3E     <= instrD[14:12];
        jalrE       <= (instrD[6:0] == opJalr);
    end

    always_comb begin
        case (dp.forwardAE)
            fwdMem:  srcAE = exResM;
            fwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (dp.forwardBE)
            fwdMem:  writeDataE = exResM;
            fwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign aluA_o  = srcAE;
    assign aluB_o  = dp.aluSrcE ? immE : writeDataE;
    assign aluOp_o = dp.aluOpE;

    // Branch resolution
    assign takenE = dp.isJumpE ||
                    (dp.isBranchE && ((funct3E == funct3Beq && aluZero_i) ||
                                      (funct3E == funct3Bne && !aluZero_i)));
    assign targetE   = jalrE ? {aluRes_i[31:1], 1'b0} : pcE + immE;
    assign redirectE = takenE ? targetE : pc4E;
    assign exResE    = dp.isJumpE ? pc4E : aluRes_i;   // Link value for jumps

    // Wrong direction, or taken to a stale target
    assign dp.mispredictE = (takenE != predTakenE) || (takenE && targetE != predTargetE);

    assign updValid_o  = dp.isBranchE || dp.isJumpE;
    assign updPc_o     = pcE;
    assign updTarget_o = targetE;
    assign updTaken_o  = takenE;
    assign updIsJump_o = dp.isJumpE;
    assign updPhtIdx_o = phtIdxE;

    // Memory and writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            dp.rdM <= 5'd0;
            dp.rdW <= 5'd0;
        end else begin
            dp.rdM <= dp.rdE;
            dp.rdW <= dp.rdM;
        end
    end

    always_ff @(posedge clk) begin
        exResM     <= exResE;
        writeDataM <= writeDataE;
        exResW     <= exResM;
        readDataW  <= dmemRData_i;
    end

    assign dmemAddr_o  = exResM;
    assign dmemWData_o = writeDataM;
    assign dmemWe_o    = dp.memWriteM;

    assign resultW = (dp.resultSrcW == resMem) ? readDataW : exResW;
    assign rfWe_o  = dp.regWriteW;
    assign rfWa_o  = dp.rdW;
    assign rfWd_o  = resultW;

endmodule

`default_nettype wire

// File: hw/riscvCore.sv
`timescale 1ns/1ps
`default_nettype none

module riscvCore #(
    parameter int btbEntries = 32,
    parameter int ghrBits    = 5
) (
    input  wire                clk,
    input  wire                reset,
    output wire  [31:0]        imemAddr_o,
    input  wire  rvPkg::instrT imemData_i,
    output wire  [31:0]        dmemAddr_o,
    output wire  [31:0]        dmemWData_o,
    output wire                dmemWe_o,
    input  wire  [31:0]        dmemRData_i,
    output wire                mispredict_o
);
    import rvPkg::*;

    logic [4:0]         ra1, ra2, rfWa;
    logic [31:0]        rd1, rd2, rfWd;
    logic               rfWe;
    logic [31:0]        aluA, aluB, aluRes;
    aluOpE              aluOp;
    logic               aluZero;
    logic               predTaken;
    logic [31:0]        predTarget;
    logic [ghrBits-1:0] phtIdx, updPhtIdx;
    logic               updValid, updTaken, updIsJump;
    logic [31:0]        updPc, updTarget;

    pipeCtrlIf ctrlIf ();

    pipeControl i_pipeControl (
        .clk  (clk),
        .reset(reset),
        .ctrl (ctrlIf.ctrl)
    );

    pipeDatapath #(.ghrBits(ghrBits)) i_pipeDatapath (
        .clk         (clk),
        .reset       (reset),
        .dp          (ctrlIf.dp),
        .imemAddr_o  (imemAddr_o),
        .imemData_i  (imemData_i),
        .ra1_o       (ra1),
        .ra2_o       (ra2),
        .rd1_i       (rd1),
        .rd2_i       (rd2),
        .rfWe_o      (rfWe),
        .rfWa_o      (rfWa),
        .rfWd_o      (rfWd),
        .aluA_o      (aluA),
        .aluB_o      (aluB),
        .aluOp_o     (aluOp),
        .aluRes_i    (aluRes),
        .aluZero_i   (aluZero),
        .predTaken_i (predTaken),
        .predTarget_i(predTarget),
        .phtIdx_i    (phtIdx),
        .updValid_o  (updValid),
        .updPc_o     (updPc),
        .updTarget_o (updTarget),
        .updTaken_o  (updTaken),
        .updIsJump_o (updIsJump),
        .updPhtIdx_o (updPhtIdx),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWData_o (dmemWData_o),
        .dmemWe_o    (dmemWe_o),
        .dmemRData_i (dmemRData_i)
    );

    branchPredictor #(
        .btbEntries(btbEntries),
        .ghrBits   (ghrBits)
    ) i_branchPredictor (
        .clk         (clk),
        .reset       (reset),
        .pcF_i       (imemAddr_o),
        .predTaken_o (predTaken),
        .predTarget_o(predTarget),
        .phtIdxF_o   (phtIdx),
        .updValid_i  (updValid),
        .updPc_i     (updPc),
        .updTarget_i (updTarget),
        .updTaken_i  (updTaken),
        .updIsJump_i (updIsJump),
        .updPhtIdx_i (updPhtIdx)
    );

    regFile i_regFile (
        .clk  (clk),
        .reset(reset),
        .ra1_i(ra1),
        .ra2_i(ra2),
        .rd1_o(rd1),
        .rd2_o(rd2),
        .we_i (rfWe),
        .wa_i (rfWa),
        .wd_i (rfWd)
    );

    alu i_alu (
        .a_i     (aluA),
        .b_i     (aluB),
        .op_i    (aluOp),
        .result_o(aluRes),
        .zero_o  (aluZero)
    );

    assign mispredict_o = ctrlIf.mispredictE;

endmodule

`default_nettype wire

// File: tb/riscvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module riscvCoreTb;
    localparam int cyclesPerProgram = 400;
    localparam int programCount     = 5;
    localparam int timeoutCycles    = cyclesPerProgram * programCount;
    localparam logic [31:0] sentinelAddr = 32'h0000_03fc;   // Last data word
    localparam int minMispredicts   = 1;   // Cold BTB
    localparam int maxMispredicts   = 5;   // History warm-up plus loop exit

    // RV32I opcodes and the sub funct7
    localparam int opcImm  = 'h13;
    localparam int opcLoad = 'h03;
    localparam int opcJalr = 'h67;
    localparam int f7Sub   = 'h20;

    logic        clk;
    logic        reset;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWData;
    logic        dmemWe;
    logic [31:0] dmemRData;
    logic        mispredict;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    logic [31:0] storeAddr [$];
    logic [31:0] storeData [$];
    time         storeTime [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [7:0]  progLen;
    logic        programDone;
    int          mispredictCount;
    int          errorCount;
    int          checkCount;
    int          cycleCount = 0;
    int          seed;

    riscvCore i_riscvCore (
        .clk         (clk),
        .reset       (reset),
        .imemAddr_o  (imemAddr),
        .imemData_i  (imemData),
        .dmemAddr_o  (dmemAddr),
        .dmemWData_o (dmemWData),
        .dmemWe_o    (dmemWe),
        .dmemRData_i (dmemRData),
        .mispredict_o(mispredict)
    );

    // Both memories answer in the same cycle
    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, a program never reached its final store",
                     cycleCount);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] aluR(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    // addi, lw and jalr share the I format
    function automatic logic [31:0] immOp(input int opc, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] luiWord(input int rd, input logic [31:0] upper);
        return {upper[31:12], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jalWord(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic appendInstr(input logic [31:0] instr);
        imem[progLen] = instr;
        progLen = progLen + 8'd1;
    endtask

    // lui plus addi, upper part rounded for the signed low part
    task automatic loadConst(input int rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h0000_0800;
        appendInstr(luiWord(rd, {upper[31:12], 12'd0}));
        appendInstr(immOp(opcImm, 0, rd, rd, {{20{value[11]}}, value[11:0]}));
    endtask

    task automatic fillMemories;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = 32'h0000_0013;   // addi x0, x0, 0
            dmem[i[7:0]] = {8'ha5, i[7:0], 8'h5a, ~i[7:0]};
        end
    endtask

    task automatic startProgram;
        @(posedge clk);
        reset <= 1'b1;
        fillMemories();
        progLen = 8'd0;
        storeAddr.delete();
        storeData.delete();
        storeTime.delete();
        expAddr.delete();
        expData.delete();
        mispredictCount = 0;
    endtask

    // Releases reset, then logs stores until the sentinel store
    task automatic runProgram;
        appendInstr(storeWord(0, 0, int'(sentinelAddr)));
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        programDone = 1'b0;
        while (!programDone) begin
            @(negedge clk);
            if (mispredict) mispredictCount++;
            if (dmemWe && dmemAddr == sentinelAddr) begin
                programDone = 1'b1;
            end else if (dmemWe) begin
                dmem[dmemAddr[9:2]] = dmemWData;
                storeAddr.push_back(dmemAddr);
                storeData.push_back(dmemWData);
                storeTime.push_back($time);
            end
        end
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic checkStores(input string name);
        checkCount++;
        assert (storeData.size() == expData.size()) else begin
            errorCount++;
            $display("%s: the program made %0d data stores where %0d were expected",
                     name, storeData.size(), expData.size());
        end
        for (int i = 0; i < expData.size() && i < storeData.size(); i++) begin
            checkCount++;
            assert (storeAddr[i] == expAddr[i]) else begin
                errorCount++;
                $display("** Error at %0t: dmemAddr_o (%s, store %0d) = 0x%08h, expected 0x%08h",
                         storeTime[i], name, i, storeAddr[i], expAddr[i]);
            end
            assert (storeData[i] == expData[i]) else begin
                errorCount++;
                $display("** Error at %0t: dmemWData_o (%s, store %0d) = 0x%08h, expected 0x%08h",
                         storeTime[i], name, i, storeData[i], expData[i]);
            end
        end
    endtask

    // Each instruction uses the result of the one before it
    task automatic aluChainTest;
        logic [31:0] a, b, r, imm, upper, sum, diff, andV, orV, sltV;
        startProgram();
        a = $random(seed);
        b = $random(seed);
        r = $random(seed);
        imm = {{20{r[11]}}, r[11:0]};
        r = $random(seed);
        upper = {r[31:12], 12'd0};
        loadConst(1, a);
        loadConst(2, b);
        appendInstr(aluR(0, 0, 3, 1, 2));          // add x3, x1, x2
        appendInstr(aluR(f7Sub, 0, 4, 1, 3));      // sub x4, x1, x3
        appendInstr(aluR(0, 7, 5, 4, 3));          // and x5, x4, x3
        appendInstr(aluR(0, 6, 6, 5, 2));          // or x6, x5, x2
        appendInstr(aluR(0, 2, 7, 4, 6));          // slt x7, x4, x6
        appendInstr(immOp(opcImm, 0, 8, 7, imm));  // addi x8, x7, imm
        appendInstr(luiWord(9, upper));
        appendInstr(storeWord(9, 0, 0));           // Store data forwarded
        for (int i = 0; i < 6; i++) begin
            appendInstr(storeWord(3 + i, 0, 4 + 4 * i));
        end
        runProgram();
        sum  = a + b;
        diff = a - sum;
        andV = diff & sum;
        orV  = andV | b;
        sltV = ($signed(diff) < $signed(orV)) ? 32'd1 : 32'd0;
        expectStore(32'd0, upper);
        expectStore(32'd4, sum);
        expectStore(32'd8, diff);
        expectStore(32'd12, andV);
        expectStore(32'd16, orV);
        expectStore(32'd20, sltV);
        expectStore(32'd24, sltV + imm);
        checkStores("alu chain");
    endtask

    task automatic loadUseTest;
        logic [31:0] valA, valB;
        startProgram();
        valA = $random(seed);
        valB = $random(seed);
        dmem[8'd16] = valA;
        dmem[8'd17] = valB;
        appendInstr(immOp(opcImm, 0, 5, 0, 77));   // addi x5, x0, 77
        appendInstr(immOp(opcLoad, 2, 1, 0, 64));  // lw x1, 64(x0)
        appendInstr(immOp(opcImm, 0, 2, 1, 100));  // addi x2, x1, 100
        appendInstr(immOp(opcLoad, 2, 3, 0, 68));  // lw x3, 68(x0)
        appendInstr(aluR(0, 0, 4, 5, 3));          // add x4, x5, x3
        appendInstr(storeWord(2, 0, 0));
        appendInstr(storeWord(4, 0, 4));
        appendInstr(immOp(opcLoad, 2, 6, 0, 0));   // Reads back the first store
        appendInstr(storeWord(6, 0, 8));           // Store data from a load
        runProgram();
        expectStore(32'd0, valA + 32'd100);
        expectStore(32'd4, valB + 32'd77);
        expectStore(32'd8, valA + 32'd100);
        checkStores("load use");
    endtask

    task automatic branchLoopTest;
        logic [31:0] expSum;
        startProgram();
        appendInstr(immOp(opcImm, 0, 1, 0, 0));    // 0: sum
        appendInstr(immOp(opcImm, 0, 2, 0, 0));    // 4: counter
        appendInstr(immOp(opcImm, 0, 3, 0, 20));   // 8: limit
        appendInstr(aluR(0, 0, 1, 1, 2));          // 12: add x1, x1, x2
        appendInstr(immOp(opcImm, 0, 2, 2, 1));    // 16: addi x2, x2, 1
        appendInstr(branch(0, 2, 0, 16));          // 20: beq x2, x0, 36
        appendInstr(branch(1, 2, 3, -12));         // 24: bne x2, x3, 12
        appendInstr(storeWord(1, 0, 0));           // 28
        appendInstr(storeWord(0, 0, int'(sentinelAddr)));
        appendInstr(immOp(opcImm, 0, 1, 1, 1000)); // 36: only on a taken beq
        appendInstr(storeWord(1, 0, 0));
        runProgram();
        expSum = 32'd0;
        for (int i = 0; i < 20; i++) begin
            expSum = expSum + i;
        end
        expectStore(32'd0, expSum);
        checkStores("branch loop");
        checkCount++;
        assert (mispredictCount >= minMispredicts && mispredictCount <= maxMispredicts)
        else begin
            errorCount++;
            $display("** Error at %0t: mispredict_o pulses = %0d, expected %0d to %0d",
                     $time, mispredictCount, minMispredicts, maxMispredicts);
        end
    endtask

    task automatic jumpTest;
        startProgram();
        appendInstr(immOp(opcImm, 0, 5, 0, 11));   // 0
        appendInstr(jalWord(0, 12));               // 4: jal x0, 16
        appendInstr(immOp(opcImm, 0, 5, 5, 100));  // 8: skipped
        appendInstr(immOp(opcImm, 0, 5, 5, 200));  // 12: skipped
        appendInstr(jalWord(1, 20));               // 16: jal x1, 36
        appendInstr(storeWord(5, 0, 4));           // 20: return lands here
        appendInstr(storeWord(7, 0, 8));           // 24
        appendInstr(storeWord(0, 0, int'(sentinelAddr)));
        appendInstr(immOp(opcImm, 0, 5, 5, 400));  // 32: never reached
        appendInstr(storeWord(1, 0, 0));           // 36: link of the call
        appendInstr(immOp(opcImm, 0, 5, 5, 1));    // 40
        appendInstr(immOp(opcJalr, 0, 7, 1, 0));   // 44: jalr x7, 0(x1)
        appendInstr(immOp(opcImm, 0, 5, 5, 800));  // 48: wrong path
        runProgram();
        expectStore(32'd0, 32'd16 + 32'd4);
        expectStore(32'd4, 32'd11 + 32'd1);
        expectStore(32'd8, 32'd44 + 32'd4);
        checkStores("jumps");
    endtask

    initial begin
        reset = 1'b1;
        seed = 32'hb34b786d;
        errorCount = 0;
        checkCount = 0;
        progLen = 8'd0;
        programDone = 1'b0;
        fillMemories();
        aluChainTest();
        aluChainTest();
        loadUseTest();
        branchLoopTest();
        jumpTest();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/rvPkg.sv
hw/pipeCtrlIf.sv
hw/branchPredictor.sv
hw/regFile.sv
hw/alu.sv
hw/pipeControl.sv
hw/pipeDatapath.sv
hw/riscvCore.sv
tb/riscvCoreTb.sv

// File: Makefile
TOP = riscvCoreTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir
